/* source/tcdm_ecc_pkg.sv */
`default_nettype none

package tcdm_ecc_pkg;

  localparam int unsigned DW         = 64;
  localparam int unsigned CHUNK_SIZE = 32;
  localparam int unsigned N_CHUNK    = DW / CHUNK_SIZE;
  localparam int unsigned AW         = 16;
  localparam int unsigned BW         = DW / 8;
  localparam int unsigned UW         = 4;
  // add, wen, be, user
  localparam int unsigned RQMETAW    = AW + 1 + BW + UW;
  // r_opc, r_user
  localparam int unsigned RSMETAW    = 1 + UW;
  localparam int unsigned EW_DW      = 7;
  localparam int unsigned EW_RQMETA  = 7;
  localparam int unsigned EW_RSMETA  = 5;
  localparam int unsigned MAX_ERR    = 2;
  localparam int unsigned BANK_WORDS = 256;

  // codeword widths, check bits above data bits
  localparam int unsigned CW_DW      = CHUNK_SIZE + EW_DW;
  localparam int unsigned CW_RQMETA  = RQMETAW + EW_RQMETA;
  // widest check field of any code in the link
  localparam int unsigned EW_MAX     = 7;

  typedef enum logic {
    OPC_OK  = 1'b0,
    OPC_ERR = 1'b1
  } r_opc_e;

  // wen high is a read
  typedef struct packed {
    logic [AW-1:0] add;
    logic          wen;
    logic [BW-1:0] be;
    logic [DW-1:0] data;
    logic [UW-1:0] user;
  } tcdm_req_t;

  typedef struct packed {
    logic [DW-1:0] r_data;
    r_opc_e        r_opc;
    logic [UW-1:0] r_user;
  } tcdm_rsp_t;

  // chunk i check bits sit at ecc[EW_RQMETA + i*EW_DW +: EW_DW]
  typedef struct packed {
    tcdm_req_t                          req;
    logic [N_CHUNK*EW_DW+EW_RQMETA-1:0] ecc;
  } tcdm_req_ecc_t;

  typedef struct packed {
    tcdm_rsp_t                          rsp;
    logic [N_CHUNK*EW_DW+EW_RSMETA-1:0] r_ecc;
  } tcdm_rsp_ecc_t;

  typedef struct packed {
    logic [MAX_ERR-1:0] data_single;
    logic [MAX_ERR-1:0] data_multi;
    logic               meta_single;
    logic               meta_multi;
  } ecc_err_t;

  // each codeword is {check, data}, chunk 0 in the low slot
  // meta_flip covers {ecc, add, wen, be, user}
  typedef struct packed {
    logic [N_CHUNK-1:0][CW_DW-1:0] data_flip;
    logic [CW_RQMETA-1:0]          meta_flip;
  } fault_t;

  // H matrix column of bit idx in a (dw data, pw check) code
  function automatic logic [EW_MAX-1:0] hsiao_col(input int unsigned idx,
                                                  input int unsigned dw,
                                                  input int unsigned pw);
    int unsigned       n;
    logic [EW_MAX-1:0] col;
    n   = 0;
    col = '0;
    if (idx >= dw) begin
      col[idx-dw] = 1'b1;
    end else begin
      // odd weight of three or more, ascending
      for (int unsigned v = 0; v < (1 << pw); v++) begin
        if ($countones(v) >= 3 && $countones(v) % 2 == 1) begin
          if (n == idx) begin
            col = v[EW_MAX-1:0];
          end
          n++;
        end
      end
    end
    return col;
  endfunction

endpackage

`default_nettype wire

/* source/hsiao_enc.sv */
`default_nettype none

module hsiao_enc #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned ProtWidth = 7
) (
  input  logic [DataWidth-1:0] data_i,
  output logic [ProtWidth-1:0] ecc_o
);

  for (genvar r = 0; r < ProtWidth; r++) begin : gen_row
    logic [DataWidth-1:0] sel;

    // data bits taking part in this check
    for (genvar b = 0; b < DataWidth; b++) begin : gen_bit
      localparam logic [tcdm_ecc_pkg::EW_MAX-1:0] COL =
        tcdm_ecc_pkg::hsiao_col(b, DataWidth, ProtWidth);
      assign sel[b] = data_i[b] & COL[r];
    end

    assign ecc_o[r] = ^sel;
  end

endmodule

`default_nettype wire

/* source/hsiao_dec.sv */
`default_nettype none

module hsiao_dec #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned ProtWidth = 7
) (
  input  logic [DataWidth-1:0] data_i,
  input  logic [ProtWidth-1:0] ecc_i,
  output logic [DataWidth-1:0] data_o,
  output logic                 single_err_o,
  output logic                 multi_err_o
);

  logic [ProtWidth-1:0] syndrome;

  for (genvar r = 0; r < ProtWidth; r++) begin : gen_row
    logic [DataWidth-1:0] sel;

    for (genvar b = 0; b < DataWidth; b++) begin : gen_bit
      localparam logic [tcdm_ecc_pkg::EW_MAX-1:0] COL =
        tcdm_ecc_pkg::hsiao_col(b, DataWidth, ProtWidth);
      assign sel[b] = data_i[b] & COL[r];
    end

    assign syndrome[r] = ecc_i[r] ^ (^sel);
  end

  // flip the data bit whose column matches the syndrome
  for (genvar b = 0; b < DataWidth; b++) begin : gen_fix
    localparam logic [tcdm_ecc_pkg::EW_MAX-1:0] COL =
      tcdm_ecc_pkg::hsiao_col(b, DataWidth, ProtWidth);
    assign data_o[b] = data_i[b] ^ (syndrome == COL[ProtWidth-1:0]);
  end

  // odd weight is correctable, even nonzero weight is not
  assign single_err_o = ^syndrome;
  assign multi_err_o  = (|syndrome) & ~(^syndrome);

endmodule

`default_nettype wire

/* source/tcdm_ecc_init.sv */
`default_nettype none

module tcdm_ecc_init (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  tcdm_ecc_pkg::tcdm_req_t     core_req_i,
  input  logic                        core_req_valid_i,
  output logic                        core_gnt_o,
  output tcdm_ecc_pkg::tcdm_rsp_t     core_rsp_o,
  output logic                        core_rsp_valid_o,
  input  logic                        core_rsp_ready_i,
  input  tcdm_ecc_pkg::fault_t        fault_i,
  output tcdm_ecc_pkg::tcdm_req_ecc_t link_req_o,
  output logic                        link_req_valid_o,
  input  logic                        link_gnt_i,
  input  tcdm_ecc_pkg::tcdm_rsp_ecc_t link_rsp_i,
  input  logic                        link_rsp_valid_i,
  output logic                        link_rsp_ready_o,
  output tcdm_ecc_pkg::ecc_err_t      rsp_err_o
);

  localparam int unsigned CS = tcdm_ecc_pkg::CHUNK_SIZE;
  localparam int unsigned NC = tcdm_ecc_pkg::N_CHUNK;
  localparam int unsigned EWD = tcdm_ecc_pkg::EW_DW;
  localparam int unsigned EWQ = tcdm_ecc_pkg::EW_RQMETA;
  localparam int unsigned EWS = tcdm_ecc_pkg::EW_RSMETA;

  tcdm_ecc_pkg::fault_t                         flip;
  logic [NC-1:0][EWD-1:0]                       req_data_ecc;
  logic [NC-1:0][tcdm_ecc_pkg::CW_DW-1:0]       data_cw;
  logic [tcdm_ecc_pkg::RQMETAW-1:0]             req_meta;
  logic [EWQ-1:0]                               req_meta_ecc;
  logic [tcdm_ecc_pkg::CW_RQMETA-1:0]           meta_cw;
  logic [tcdm_ecc_pkg::DW-1:0]                  rsp_data;
  logic [NC-1:0]                                rsp_single;
  logic [NC-1:0]                                rsp_multi;
  logic [tcdm_ecc_pkg::RSMETAW-1:0]             rsp_meta;
  logic                                         rsp_meta_single;
  logic                                         rsp_meta_multi;

  // masks only act on a live request
  assign flip = core_req_valid_i ? fault_i : '0;

  assign req_meta = {core_req_i.add, core_req_i.wen, core_req_i.be, core_req_i.user};

  for (genvar ii = 0; ii < NC; ii++) begin : gen_chunk
    hsiao_enc #(.DataWidth(CS), .ProtWidth(EWD)) i_req_data_enc (
      .data_i (core_req_i.data[ii*CS +: CS]),
      .ecc_o  (req_data_ecc[ii])
    );

    assign data_cw[ii] = {req_data_ecc[ii], core_req_i.data[ii*CS +: CS]}
                         ^ flip.data_flip[ii];

    hsiao_dec #(.DataWidth(CS), .ProtWidth(EWD)) i_rsp_data_dec (
      .data_i       (link_rsp_i.rsp.r_data[ii*CS +: CS]),
      .ecc_i        (link_rsp_i.r_ecc[EWS+ii*EWD +: EWD]),
      .data_o       (rsp_data[ii*CS +: CS]),
      .single_err_o (rsp_single[ii]),
      .multi_err_o  (rsp_multi[ii])
    );
  end

  hsiao_enc #(.DataWidth(tcdm_ecc_pkg::RQMETAW), .ProtWidth(EWQ)) i_req_meta_enc (
    .data_i (req_meta),
    .ecc_o  (req_meta_ecc)
  );

  assign meta_cw = {req_meta_ecc, req_meta} ^ flip.meta_flip;

  always_comb begin
    {link_req_o.req.add, link_req_o.req.wen, link_req_o.req.be, link_req_o.req.user} =
      meta_cw[tcdm_ecc_pkg::RQMETAW-1:0];
    link_req_o.ecc[EWQ-1:0] = meta_cw[tcdm_ecc_pkg::CW_RQMETA-1:tcdm_ecc_pkg::RQMETAW];
    for (int ii = 0; ii < NC; ii++) begin
      link_req_o.req.data[ii*CS +: CS] = data_cw[ii][CS-1:0];
      link_req_o.ecc[EWQ+ii*EWD +: EWD] = data_cw[ii][tcdm_ecc_pkg::CW_DW-1:CS];
    end
  end

  hsiao_dec #(.DataWidth(tcdm_ecc_pkg::RSMETAW), .ProtWidth(EWS)) i_rsp_meta_dec (
    .data_i       ({link_rsp_i.rsp.r_opc, link_rsp_i.rsp.r_user}),
    .ecc_i        (link_rsp_i.r_ecc[EWS-1:0]),
    .data_o       (rsp_meta),
    .single_err_o (rsp_meta_single),
    .multi_err_o  (rsp_meta_multi)
  );

  // field order of tcdm_rsp_t is r_data, r_opc, r_user
  assign core_rsp_o = {rsp_data, rsp_meta};

  always_comb begin
    rsp_err_o.data_single = tcdm_ecc_pkg::MAX_ERR'($countones(rsp_single));
    rsp_err_o.data_multi  = tcdm_ecc_pkg::MAX_ERR'($countones(rsp_multi));
    rsp_err_o.meta_single = rsp_meta_single;
    rsp_err_o.meta_multi  = rsp_meta_multi;
  end

  assign link_req_valid_o = core_req_valid_i;
  assign core_gnt_o       = link_gnt_i;
  assign core_rsp_valid_o = link_rsp_valid_i;
  assign link_rsp_ready_o = core_rsp_ready_i;

  // a waiting core request keeps its payload
  assert property (@(posedge clk_i) disable iff (rst_i)
    core_req_valid_i && !core_gnt_o |=> core_req_valid_i && $stable(core_req_i))
    else $error("tcdm_ecc_init: request changed before grant");

endmodule

`default_nettype wire

/* source/tcdm_ecc_target.sv */
`default_nettype none

module tcdm_ecc_target (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  tcdm_ecc_pkg::tcdm_req_ecc_t link_req_i,
  input  logic                        link_req_valid_i,
  output logic                        link_gnt_o,
  output tcdm_ecc_pkg::tcdm_rsp_ecc_t link_rsp_o,
  output logic                        link_rsp_valid_o,
  input  logic                        link_rsp_ready_i,
  output tcdm_ecc_pkg::tcdm_req_t     bank_req_o,
  output logic                        bank_req_valid_o,
  input  logic                        bank_gnt_i,
  input  tcdm_ecc_pkg::tcdm_rsp_t     bank_rsp_i,
  input  logic                        bank_rsp_valid_i,
  output logic                        bank_rsp_ready_o,
  output tcdm_ecc_pkg::ecc_err_t      req_err_o
);

  localparam int unsigned CS = tcdm_ecc_pkg::CHUNK_SIZE;
  localparam int unsigned NC = tcdm_ecc_pkg::N_CHUNK;
  localparam int unsigned EWD = tcdm_ecc_pkg::EW_DW;
  localparam int unsigned EWQ = tcdm_ecc_pkg::EW_RQMETA;
  localparam int unsigned EWS = tcdm_ecc_pkg::EW_RSMETA;

  logic [tcdm_ecc_pkg::DW-1:0]      req_data_fix;
  logic [NC-1:0]                    req_single;
  logic [NC-1:0]                    req_multi;
  logic [tcdm_ecc_pkg::RQMETAW-1:0] req_meta_fix;
  logic                             meta_single;
  logic                             meta_multi;
  logic                             meta_err_q;
  tcdm_ecc_pkg::r_opc_e             rsp_opc;
  logic [NC-1:0][EWD-1:0]           rsp_data_ecc;
  logic [EWS-1:0]                   rsp_meta_ecc;

  for (genvar ii = 0; ii < NC; ii++) begin : gen_chunk
    hsiao_dec #(.DataWidth(CS), .ProtWidth(EWD)) i_req_data_dec (
      .data_i       (link_req_i.req.data[ii*CS +: CS]),
      .ecc_i        (link_req_i.ecc[EWQ+ii*EWD +: EWD]),
      .data_o       (req_data_fix[ii*CS +: CS]),
      .single_err_o (req_single[ii]),
      .multi_err_o  (req_multi[ii])
    );

    hsiao_enc #(.DataWidth(CS), .ProtWidth(EWD)) i_rsp_data_enc (
      .data_i (bank_rsp_i.r_data[ii*CS +: CS]),
      .ecc_o  (rsp_data_ecc[ii])
    );
  end

  hsiao_dec #(.DataWidth(tcdm_ecc_pkg::RQMETAW), .ProtWidth(EWQ)) i_req_meta_dec (
    .data_i       ({link_req_i.req.add, link_req_i.req.wen, link_req_i.req.be,
                    link_req_i.req.user}),
    .ecc_i        (link_req_i.ecc[EWQ-1:0]),
    .data_o       (req_meta_fix),
    .single_err_o (meta_single),
    .multi_err_o  (meta_multi)
  );

  always_comb begin
    {bank_req_o.add, bank_req_o.wen, bank_req_o.be, bank_req_o.user} = req_meta_fix;
    bank_req_o.data = req_data_fix;
    // address or be may be wrong, so never write
    if (meta_multi) begin
      bank_req_o.wen = 1'b1;
    end
  end

  always_comb begin
    req_err_o.data_single = tcdm_ecc_pkg::MAX_ERR'($countones(req_single));
    req_err_o.data_multi  = tcdm_ecc_pkg::MAX_ERR'($countones(req_multi));
    req_err_o.meta_single = meta_single;
    req_err_o.meta_multi  = meta_multi;
  end

  // marks the pending response as belonging to a broken request
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      meta_err_q <= 1'b0;
    end else if (link_req_valid_i && bank_gnt_i) begin
      meta_err_q <= meta_multi;
    end else if (link_rsp_valid_o && link_rsp_ready_i) begin
      meta_err_q <= 1'b0;
    end
  end

  assign rsp_opc = meta_err_q ? tcdm_ecc_pkg::OPC_ERR : bank_rsp_i.r_opc;

  hsiao_enc #(.DataWidth(tcdm_ecc_pkg::RSMETAW), .ProtWidth(EWS)) i_rsp_meta_enc (
    .data_i ({rsp_opc, bank_rsp_i.r_user}),
    .ecc_o  (rsp_meta_ecc)
  );

  always_comb begin
    link_rsp_o.rsp.r_data = bank_rsp_i.r_data;
    link_rsp_o.rsp.r_opc  = rsp_opc;
    link_rsp_o.rsp.r_user = bank_rsp_i.r_user;
    link_rsp_o.r_ecc      = {rsp_data_ecc, rsp_meta_ecc};
  end

  assign bank_req_valid_o = link_req_valid_i;
  assign link_gnt_o       = bank_gnt_i;
  assign link_rsp_valid_o = bank_rsp_valid_i;
  assign bank_rsp_ready_o = link_rsp_ready_i;

  // broken metadata comes back as an error on the next cycle
  assert property (@(posedge clk_i) disable iff (rst_i)
    link_req_valid_i && link_gnt_o && meta_multi
    |=> link_rsp_valid_o && link_rsp_o.rsp.r_opc == tcdm_ecc_pkg::OPC_ERR)
    else $error("tcdm_ecc_target: metadata error not reported as OPC_ERR");

endmodule

`default_nettype wire

/* source/tcdm_bank.sv */
`default_nettype none

module tcdm_bank (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  tcdm_ecc_pkg::tcdm_req_t req_i,
  input  logic                    req_valid_i,
  output logic                    gnt_o,
  output tcdm_ecc_pkg::tcdm_rsp_t rsp_o,
  output logic                    rsp_valid_o,
  input  logic                    rsp_ready_i
);

  localparam int unsigned OFFS = $clog2(tcdm_ecc_pkg::BW);
  localparam int unsigned IDXW = $clog2(tcdm_ecc_pkg::BANK_WORDS);

  logic [tcdm_ecc_pkg::DW-1:0] mem [tcdm_ecc_pkg::BANK_WORDS];
  logic [IDXW-1:0]             idx;
  logic [tcdm_ecc_pkg::DW-1:0] merged;
  logic                        grant;

  assign idx = req_i.add[OFFS +: IDXW];

  // free slot, or the held response leaves this cycle
  assign gnt_o = req_valid_i && (!rsp_valid_o || rsp_ready_i);
  assign grant = gnt_o;

  always_comb begin
    merged = mem[idx];
    for (int b = 0; b < tcdm_ecc_pkg::BW; b++) begin
      if (req_i.be[b]) begin
        merged[b*8 +: 8] = req_i.data[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant) begin
      if (!req_i.wen) begin
        mem[idx] <= merged;
      end
      rsp_o.r_data <= req_i.wen ? mem[idx] : merged;
      rsp_o.r_opc  <= tcdm_ecc_pkg::OPC_OK;
      rsp_o.r_user <= req_i.user;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_o <= 1'b0;
    end else if (grant) begin
      rsp_valid_o <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_o <= 1'b0;
    end
  end

  // held response must not move
  assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
    else $error("tcdm_bank: response changed under back-pressure");

endmodule

`default_nettype wire

/* source/tcdm_ecc_top.sv */
`default_nettype none

module tcdm_ecc_top (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  tcdm_ecc_pkg::tcdm_req_t core_req_i,
  input  logic                    core_req_valid_i,
  output logic                    core_gnt_o,
  output tcdm_ecc_pkg::tcdm_rsp_t core_rsp_o,
  output logic                    core_rsp_valid_o,
  input  logic                    core_rsp_ready_i,
  input  tcdm_ecc_pkg::fault_t    fault_i,
  output tcdm_ecc_pkg::ecc_err_t  req_err_o,
  output tcdm_ecc_pkg::ecc_err_t  rsp_err_o
);

  // protected link between the shims
  tcdm_ecc_pkg::tcdm_req_ecc_t link_req;
  logic                        link_req_valid;
  logic                        link_gnt;
  tcdm_ecc_pkg::tcdm_rsp_ecc_t link_rsp;
  logic                        link_rsp_valid;
  logic                        link_rsp_ready;

  // plain bank port
  tcdm_ecc_pkg::tcdm_req_t     bank_req;
  logic                        bank_req_valid;
  logic                        bank_gnt;
  tcdm_ecc_pkg::tcdm_rsp_t     bank_rsp;
  logic                        bank_rsp_valid;
  logic                        bank_rsp_ready;

  tcdm_ecc_init i_init (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .core_req_i       (core_req_i),
    .core_req_valid_i (core_req_valid_i),
    .core_gnt_o       (core_gnt_o),
    .core_rsp_o       (core_rsp_o),
    .core_rsp_valid_o (core_rsp_valid_o),
    .core_rsp_ready_i (core_rsp_ready_i),
    .fault_i          (fault_i),
    .link_req_o       (link_req),
    .link_req_valid_o (link_req_valid),
    .link_gnt_i       (link_gnt),
    .link_rsp_i       (link_rsp),
    .link_rsp_valid_i (link_rsp_valid),
    .link_rsp_ready_o (link_rsp_ready),
    .rsp_err_o        (rsp_err_o)
  );

  tcdm_ecc_target i_target (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .link_req_i       (link_req),
    .link_req_valid_i (link_req_valid),
    .link_gnt_o       (link_gnt),
    .link_rsp_o       (link_rsp),
    .link_rsp_valid_o (link_rsp_valid),
    .link_rsp_ready_i (link_rsp_ready),
    .bank_req_o       (bank_req),
    .bank_req_valid_o (bank_req_valid),
    .bank_gnt_i       (bank_gnt),
    .bank_rsp_i       (bank_rsp),
    .bank_rsp_valid_i (bank_rsp_valid),
    .bank_rsp_ready_o (bank_rsp_ready),
    .req_err_o        (req_err_o)
  );

  tcdm_bank i_bank (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (bank_req),
    .req_valid_i (bank_req_valid),
    .gnt_o       (bank_gnt),
    .rsp_o       (bank_rsp),
    .rsp_valid_o (bank_rsp_valid),
    .rsp_ready_i (bank_rsp_ready)
  );

endmodule

`default_nettype wire

/* tests/tb_tcdm_ecc_checks.svh */
`ifndef TB_TCDM_ECC_CHECKS_SVH
`define TB_TCDM_ECC_CHECKS_SVH

localparam int unsigned IDX_LO = $clog2(tcdm_ecc_pkg::BW);
localparam int unsigned IDX_W  = $clog2(tcdm_ecc_pkg::BANK_WORDS);
localparam int unsigned CS     = tcdm_ecc_pkg::CHUNK_SIZE;
localparam int unsigned CWD    = tcdm_ecc_pkg::CW_DW;
localparam int unsigned CWM    = tcdm_ecc_pkg::CW_RQMETA;

// reference copy of the bank, keyed by word index
logic [tcdm_ecc_pkg::DW-1:0] model_mem [int unsigned];
int unsigned                 err_count;

// n distinct set bits below width
function automatic logic [63:0] rand_flips(input int unsigned width, input int unsigned n);
  logic [63:0] m;
  m = '0;
  while ($countones(m) < n) begin
    m[$urandom_range(width - 1, 0)] = 1'b1;
  end
  return m;
endfunction

// initial bank contents, distinct for every word index
function automatic logic [tcdm_ecc_pkg::DW-1:0] fill_word(input int unsigned idx);
  logic [7:0] b;
  b = idx[7:0];
  return {4{~b, b ^ 8'h5a}};
endfunction

function automatic tcdm_ecc_pkg::tcdm_req_t rand_req(input logic is_read);
  tcdm_ecc_pkg::tcdm_req_t r;
  r.add  = tcdm_ecc_pkg::AW'($urandom);
  r.wen  = is_read;
  r.be   = tcdm_ecc_pkg::BW'($urandom);
  r.data = {$urandom, $urandom};
  r.user = tcdm_ecc_pkg::UW'($urandom);
  return r;
endfunction

// one flip per codeword is corrected, two are only detected
function automatic tcdm_ecc_pkg::ecc_err_t predict_err(input tcdm_ecc_pkg::fault_t f);
  tcdm_ecc_pkg::ecc_err_t e;
  e = '0;
  for (int c = 0; c < tcdm_ecc_pkg::N_CHUNK; c++) begin
    if ($countones(f.data_flip[c]) == 1) begin
      e.data_single = e.data_single + 1'b1;
    end
    if ($countones(f.data_flip[c]) == 2) begin
      e.data_multi = e.data_multi + 1'b1;
    end
  end
  e.meta_single = ($countones(f.meta_flip) == 1);
  e.meta_multi  = ($countones(f.meta_flip) == 2);
  return e;
endfunction

// what the bank sees after the link, applied to the model
function automatic tcdm_ecc_pkg::tcdm_rsp_t apply_to_model(input tcdm_ecc_pkg::tcdm_req_t req,
                                                          input tcdm_ecc_pkg::fault_t f);
  tcdm_ecc_pkg::tcdm_req_t     eff;
  tcdm_ecc_pkg::tcdm_rsp_t     rsp;
  logic [tcdm_ecc_pkg::DW-1:0] word;
  int unsigned                 idx;
  eff = req;
  // uncorrectable metadata arrives garbled and becomes a read
  if ($countones(f.meta_flip) == 2) begin
    {eff.add, eff.wen, eff.be, eff.user} = {req.add, req.wen, req.be, req.user}
                                           ^ f.meta_flip[tcdm_ecc_pkg::RQMETAW-1:0];
    eff.wen = 1'b1;
  end
  for (int c = 0; c < tcdm_ecc_pkg::N_CHUNK; c++) begin
    if ($countones(f.data_flip[c]) == 2) begin
      eff.data[c*CS +: CS] = req.data[c*CS +: CS] ^ f.data_flip[c][CS-1:0];
    end
  end
  idx  = eff.add[IDX_LO +: IDX_W];
  word = model_mem[idx];
  if (!eff.wen) begin
    for (int b = 0; b < tcdm_ecc_pkg::BW; b++) begin
      if (eff.be[b]) begin
        word[b*8 +: 8] = eff.data[b*8 +: 8];
      end
    end
    model_mem[idx] = word;
  end
  rsp.r_data = word;
  rsp.r_opc  = ($countones(f.meta_flip) == 2) ? tcdm_ecc_pkg::OPC_ERR : tcdm_ecc_pkg::OPC_OK;
  rsp.r_user = eff.user;
  return rsp;
endfunction

task automatic check_rsp(input string name, input tcdm_ecc_pkg::tcdm_rsp_t got,
                         input tcdm_ecc_pkg::tcdm_rsp_t exp);
  if (got.r_data !== exp.r_data) begin
    $display("MISMATCH %s.r_data: got %h, expected %h", name, got.r_data, exp.r_data);
    err_count++;
  end
  if (got.r_opc !== exp.r_opc) begin
    $display("MISMATCH %s.r_opc: got %h, expected %h", name, got.r_opc, exp.r_opc);
    err_count++;
  end
  if (got.r_user !== exp.r_user) begin
    $display("MISMATCH %s.r_user: got %h, expected %h", name, got.r_user, exp.r_user);
    err_count++;
  end
endtask

task automatic check_err(input string name, input tcdm_ecc_pkg::ecc_err_t got,
                         input tcdm_ecc_pkg::ecc_err_t exp);
  if (got !== exp) begin
    $display("MISMATCH %s: got %h, expected %h (data_single, data_multi, meta_s, meta_m)",
             name, got, exp);
    err_count++;
  end
endtask

`endif

/* tests/tb_tcdm_ecc.sv */
`default_nettype none

module tb_tcdm_ecc;

  localparam int CLK_PERIOD = 20;
  localparam int SETTLE     = CLK_PERIOD / 4;
  localparam int TIMEOUT    = 50;

  logic                    clk;
  logic                    rst;
  tcdm_ecc_pkg::tcdm_req_t core_req;
  logic                    core_req_valid;
  logic                    core_gnt;
  tcdm_ecc_pkg::tcdm_rsp_t core_rsp;
  logic                    core_rsp_valid;
  logic                    core_rsp_ready;
  tcdm_ecc_pkg::fault_t    fault;
  tcdm_ecc_pkg::ecc_err_t  req_err;
  tcdm_ecc_pkg::ecc_err_t  rsp_err;

  // response still owed for the last granted request
  logic                    pending;
  tcdm_ecc_pkg::tcdm_rsp_t pending_rsp;
  int unsigned             n_issued;
  int unsigned             n_accepted;
  int unsigned             n_tests;
  int unsigned             n_failed;
  int unsigned             test_err_base;

  `include "tb_tcdm_ecc_checks.svh"

  tcdm_ecc_top i_dut (
    .clk_i            (clk),
    .rst_i            (rst),
    .core_req_i       (core_req),
    .core_req_valid_i (core_req_valid),
    .core_gnt_o       (core_gnt),
    .core_rsp_o       (core_rsp),
    .core_rsp_valid_o (core_rsp_valid),
    .core_rsp_ready_i (core_rsp_ready),
    .fault_i          (fault),
    .req_err_o        (req_err),
    .rsp_err_o        (rsp_err)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // responses the DUT hands over on the core port
  always @(posedge clk) begin
    if (!rst && core_rsp_valid && core_rsp_ready) begin
      n_accepted++;
    end
  end

  task automatic report_timeout(input string what);
    $display("ERROR: timed out waiting for %s", what);
    $display("FAIL: see errors above");
    $finish;
  endtask

  // sample points sit a quarter period after the falling edge
  task automatic wait_grant();
    int unsigned n;
    n = 0;
    while (!core_gnt && n < TIMEOUT) begin
      @(negedge clk);
      #(SETTLE);
      n++;
    end
    if (!core_gnt) begin
      report_timeout("core_gnt_o");
    end
  endtask

  // called in the cycle right after a grant
  task automatic wait_valid();
    int unsigned n;
    n = 0;
    while (!core_rsp_valid && n < TIMEOUT) begin
      @(negedge clk);
      #(SETTLE);
      n++;
    end
    if (!core_rsp_valid) begin
      report_timeout("core_rsp_valid_o");
    end else if (n != 0) begin
      $display("ERROR: response arrived %0d cycles late", n);
      err_count++;
    end
  endtask

  task automatic hold_response(input int unsigned stall);
    for (int unsigned n = 0; n < stall; n++) begin
      if (core_gnt) begin
        $display("ERROR: request granted while the response was held");
        err_count++;
      end
      if (!core_rsp_valid) begin
        $display("ERROR: response valid dropped under back-pressure");
        err_count++;
      end
      check_rsp("core_rsp_o", core_rsp, pending_rsp);
      @(negedge clk);
      core_rsp_ready = (n == stall - 1);
      #(SETTLE);
    end
  endtask

  task automatic accept_response();
    check_rsp("core_rsp_o", core_rsp, pending_rsp);
    check_err("rsp_err_o", rsp_err, '0);
  endtask

  // next request goes out while the previous response is still held
  task automatic issue(input tcdm_ecc_pkg::tcdm_req_t req, input tcdm_ecc_pkg::fault_t f,
                       input int unsigned stall);
    tcdm_ecc_pkg::ecc_err_t  exp_err;
    tcdm_ecc_pkg::tcdm_rsp_t exp_rsp;
    exp_err = predict_err(f);
    exp_rsp = apply_to_model(req, f);
    @(negedge clk);
    core_req       = req;
    core_req_valid = 1'b1;
    fault          = f;
    core_rsp_ready = !(pending && stall > 0);
    #(SETTLE);
    if (pending) begin
      wait_valid();
      hold_response(stall);
    end
    wait_grant();
    check_err("req_err_o", req_err, exp_err);
    if (pending) begin
      accept_response();
    end
    n_issued++;
    pending     = 1'b1;
    pending_rsp = exp_rsp;
  endtask

  task automatic drain(input int unsigned stall);
    if (pending) begin
      @(negedge clk);
      core_req_valid = 1'b0;
      fault          = '0;
      core_rsp_ready = (stall == 0);
      #(SETTLE);
      wait_valid();
      hold_response(stall);
      accept_response();
      @(negedge clk);
      core_rsp_ready = 1'b0;
      #(SETTLE);
      if (core_rsp_valid) begin
        $display("ERROR: response still valid after it was accepted");
        err_count++;
      end
      pending = 1'b0;
    end
  endtask

  task automatic start_test();
    test_err_base = err_count;
  endtask

  task automatic finish_test(input string name);
    n_tests++;
    if (err_count != test_err_base) begin
      n_failed++;
    end
    $display("test %-14s %0d errors", name, err_count - test_err_base);
  endtask

  task automatic read_back(ref logic [tcdm_ecc_pkg::AW-1:0] addr_q [$]);
    tcdm_ecc_pkg::tcdm_req_t req;
    foreach (addr_q[i]) begin
      req     = rand_req(1'b1);
      req.add = addr_q[i];
      issue(req, '0, 0);
    end
    addr_q.delete();
  endtask

  initial begin
    tcdm_ecc_pkg::tcdm_req_t     req;
    tcdm_ecc_pkg::fault_t        f;
    logic [tcdm_ecc_pkg::AW-1:0] addr_q [$];
    int unsigned                 hits;

    void'($urandom(88696));
    rst            = 1'b1;
    core_req       = '0;
    core_req_valid = 1'b0;
    core_rsp_ready = 1'b0;
    fault          = '0;
    pending        = 1'b0;
    pending_rsp    = '0;
    err_count      = 0;
    n_issued       = 0;
    n_accepted     = 0;
    n_tests        = 0;
    n_failed       = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    start_test();
    #(SETTLE);
    if (core_gnt || core_rsp_valid) begin
      $display("ERROR: grant or response valid high after reset");
      err_count++;
    end
    finish_test("reset");

    // every word written once so later reads are defined
    start_test();
    for (int unsigned w = 0; w < tcdm_ecc_pkg::BANK_WORDS; w++) begin
      req                      = rand_req(1'b0);
      req.add[IDX_LO +: IDX_W] = IDX_W'(w);
      req.be                   = '1;
      req.data                 = fill_word(w);
      issue(req, '0, 0);
    end
    drain(0);
    finish_test("fill");

    start_test();
    for (int i = 0; i < 40; i++) begin
      req = rand_req(1'b0);
      addr_q.push_back(req.add);
      issue(req, '0, 0);
    end
    read_back(addr_q);
    drain(0);
    finish_test("clean");

    start_test();
    for (int i = 0; i < 60; i++) begin
      req  = rand_req(1'($urandom));
      f    = '0;
      hits = $urandom_range(3, 1);
      for (int c = 0; c < tcdm_ecc_pkg::N_CHUNK; c++) begin
        if (hits[c]) begin
          f.data_flip[c] = CWD'(rand_flips(CWD, 1));
        end
      end
      addr_q.push_back(req.add);
      issue(req, f, 0);
    end
    read_back(addr_q);
    drain(0);
    finish_test("data_single");

    start_test();
    for (int i = 0; i < 30; i++) begin
      req = rand_req(1'b0);
      f   = '0;
      f.data_flip[$urandom_range(tcdm_ecc_pkg::N_CHUNK - 1, 0)] = CWD'(rand_flips(CWD, 2));
      addr_q.push_back(req.add);
      issue(req, f, 0);
    end
    read_back(addr_q);
    drain(0);
    finish_test("data_double");

    // alternate one and two flips over the metadata codeword
    start_test();
    for (int i = 0; i < 60; i++) begin
      req         = rand_req(1'($urandom));
      f           = '0;
      f.meta_flip = CWM'(rand_flips(CWM, (i % 2) + 1));
      addr_q.push_back(req.add);
      issue(req, f, 0);
    end
    read_back(addr_q);
    drain(0);
    finish_test("meta");

    // few words, so reordering or loss shows up in the data
    start_test();
    for (int i = 0; i < 60; i++) begin
      req                      = rand_req(1'($urandom));
      req.add[IDX_LO +: IDX_W] = IDX_W'($urandom_range(7, 0));
      issue(req, '0, $urandom_range(5, 0));
    end
    drain($urandom_range(5, 1));
    if (n_accepted != n_issued) begin
      $display("ERROR: %0d requests granted but %0d responses accepted", n_issued, n_accepted);
      err_count++;
    end
    finish_test("backpressure");

    $display("summary: %0d tests, %0d failed, %0d errors", n_tests, n_failed, err_count);
    if (err_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+tests
source/tcdm_ecc_pkg.sv
source/hsiao_enc.sv
source/hsiao_dec.sv
source/tcdm_ecc_init.sv
source/tcdm_ecc_target.sv
source/tcdm_bank.sv
source/tcdm_ecc_top.sv
tests/tb_tcdm_ecc.sv

/* Bender.yml */
package:
  name: tcdm_ecc

sources:
  - files:
      - source/tcdm_ecc_pkg.sv
      - source/hsiao_enc.sv
      - source/hsiao_dec.sv
      - source/tcdm_ecc_init.sv
      - source/tcdm_ecc_target.sv
      - source/tcdm_bank.sv
      - source/tcdm_ecc_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_tcdm_ecc.sv
